// File: i2c_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c eeprom master shared definitions
// bus timing, command flags and state types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package i2c_pkg;

	localparam int clk_freq = 25_000_000;                  // system clock in hz
	localparam int scl_freq = 250_000;                     // bus rate in hz
	localparam int scl_max = clk_freq / scl_freq;          // system cycles per bit
	localparam int scl_low_half = (scl_max * 1 / 4) - 1;   // sda changes here, scl is low
	localparam int scl_high_half = (scl_max * 3 / 4) - 1;  // sda is sampled here, scl is high

	// command flags are one-hot and get or-ed together into one entry
	localparam int cmd_w = 5;
	localparam logic [cmd_w-1:0] cmd_start = 5'b00001;
	localparam logic [cmd_w-1:0] cmd_write = 5'b00010;
	localparam logic [cmd_w-1:0] cmd_read = 5'b00100;
	localparam logic [cmd_w-1:0] cmd_stop = 5'b01000;
	localparam logic [cmd_w-1:0] cmd_nack = 5'b10000;  // send a not-acknowledge after a read

	localparam logic [6:0] dev_addr = 7'h50;  // eeprom with its address pins tied low
	localparam int fifo_depth = 4;             // one full read transfer fits

	typedef enum logic [2:0] {
		bus_idle,
		bus_start,
		bus_wr_data,
		bus_rd_data,
		bus_r_ack,
		bus_t_ack,
		bus_stop
	} bus_state_t;

	typedef enum logic [1:0] {ctrl_idle, ctrl_push, ctrl_wait_done} ctrl_state_t;

endpackage

`default_nettype wire

// File: i2c_cmd_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c command buffer
// holds command entries and hands them to the byte engine one at a time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module i2c_cmd_fifo (
	input  wire                        sys_clk,
	input  wire                        sys_rst_n,
	input  wire                        push,
	input  wire  [i2c_pkg::cmd_w-1:0]  cmd_in,
	input  wire  [7:0]                 data_in,
	input  wire                        idle,
	output logic                       cmd_vld,
	output logic [i2c_pkg::cmd_w-1:0]  cmd,
	output logic [7:0]                 wr_data
);

	logic [i2c_pkg::cmd_w-1:0] cmd_mem [i2c_pkg::fifo_depth];
	logic [7:0] data_mem [i2c_pkg::fifo_depth];
	logic [$clog2(i2c_pkg::fifo_depth)-1:0] wr_ptr;
	logic [$clog2(i2c_pkg::fifo_depth)-1:0] rd_ptr;
	logic [$clog2(i2c_pkg::fifo_depth+1)-1:0] count;
	logic pop;

	// a pulse that went out last cycle is still in flight, the engine leaves idle only now
	assign pop = idle && (count != '0) && !cmd_vld;

	always_ff @(posedge sys_clk) begin
		if (push) begin
			cmd_mem[wr_ptr] <= cmd_in;
			data_mem[wr_ptr] <= data_in;
		end
		if (pop) begin
			cmd <= cmd_mem[rd_ptr];      // head entry goes out with the strobe
			wr_data <= data_mem[rd_ptr];
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cmd_vld <= 1'b0;
		end else begin
			cmd_vld <= pop;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so pointers wrap
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: eeprom_access_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eeprom request sequencer
// turns a single-byte read or write into bus command entries
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module eeprom_access_ctrl (
	input  wire                        sys_clk,
	input  wire                        sys_rst_n,
	input  wire                        req,
	input  wire                        req_write,
	input  wire  [7:0]                 mem_addr,
	input  wire  [7:0]                 wr_data,
	input  wire                        done,
	input  wire                        rev_ack,
	output logic                       push,
	output logic [i2c_pkg::cmd_w-1:0]  cmd_in,
	output logic [7:0]                 data_in,
	output logic                       busy,
	output logic                       xfer_done,
	output logic                       ack_err
);

	i2c_pkg::ctrl_state_t state;
	logic write_r;
	logic [7:0] mem_addr_r;
	logic [7:0] wr_data_r;
	logic [1:0] entry_idx;
	logic [1:0] done_cnt;
	logic [1:0] last_idx;
	logic accept;

	assign accept = req && (state == i2c_pkg::ctrl_idle);  // requests while busy are dropped
	assign busy = (state != i2c_pkg::ctrl_idle);
	assign push = (state == i2c_pkg::ctrl_push);
	assign last_idx = write_r ? 2'd2 : 2'd3;  // three entries for a write, four for a read

	always_comb begin
		case (entry_idx)
			2'd0: begin
				cmd_in = i2c_pkg::cmd_start | i2c_pkg::cmd_write;
				data_in = {i2c_pkg::dev_addr, 1'b0};
			end
			2'd1: begin
				cmd_in = i2c_pkg::cmd_write;
				data_in = mem_addr_r;
			end
			2'd2: begin
				if (write_r) begin
					cmd_in = i2c_pkg::cmd_write | i2c_pkg::cmd_stop;
					data_in = wr_data_r;
				end else begin
					cmd_in = i2c_pkg::cmd_start | i2c_pkg::cmd_write;  // repeated start
					data_in = {i2c_pkg::dev_addr, 1'b1};
				end
			end
			default: begin
				cmd_in = i2c_pkg::cmd_read | i2c_pkg::cmd_nack | i2c_pkg::cmd_stop;
				data_in = 8'h00;
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			mem_addr_r <= mem_addr;
			wr_data_r <= wr_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= i2c_pkg::ctrl_idle;
			write_r <= 1'b0;
			entry_idx <= '0;
			done_cnt <= '0;
			xfer_done <= 1'b0;
			ack_err <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			case (state)
				i2c_pkg::ctrl_idle: begin
					if (accept) begin
						write_r <= req_write;
						entry_idx <= '0;
						done_cnt <= '0;
						ack_err <= 1'b0;
						state <= i2c_pkg::ctrl_push;
					end
				end
				i2c_pkg::ctrl_push: begin
					entry_idx <= entry_idx + 1'b1;
					if (entry_idx == last_idx)
						state <= i2c_pkg::ctrl_wait_done;
				end
				i2c_pkg::ctrl_wait_done: begin
					if (xfer_done)
						state <= i2c_pkg::ctrl_idle;  // busy drops after the done cycle
				end
				default: state <= i2c_pkg::ctrl_idle;
			endcase
			if (busy && done) begin
				ack_err <= ack_err | rev_ack;  // high rev_ack means the slave did not ack
				done_cnt <= done_cnt + 1'b1;
				if (done_cnt == last_idx)
					xfer_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: i2c_byte_master.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c byte engine
// runs start, byte write, byte read, ack and stop on scl and sda
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module i2c_byte_master (
	input  wire                        sys_clk,
	input  wire                        sys_rst_n,
	input  wire                        cmd_vld,
	input  wire  [i2c_pkg::cmd_w-1:0]  cmd,
	input  wire  [7:0]                 wr_data,
	output logic                       idle,
	output logic                       done,
	output logic                       rev_ack,
	output logic [7:0]                 rd_data,
	output logic                       rd_data_vld,
	output logic                       scl,
	inout  wire                        sda
);

	typedef logic [$clog2(i2c_pkg::scl_max)-1:0] cnt_bit_t;

	i2c_pkg::bus_state_t state;
	i2c_pkg::bus_state_t next_state;
	logic [i2c_pkg::cmd_w-1:0] cmd_r;
	logic [7:0] wr_data_r;
	cnt_bit_t cnt_bit;
	logic [2:0] cnt_num;   // bit position inside the current state
	logic [3:0] num;       // bits the current state lasts
	logic sda_out;
	logic oe;
	logic end_cnt_bit;
	logic end_cnt_num;
	logic stop_req;
	logic go_start;
	logic go_wr;
	logic go_rd;
	logic start_end;
	logic wr_end;
	logic rd_end;
	logic ack_end;
	logic r_ack_stop;
	logic stop_end;

	assign idle = (state == i2c_pkg::bus_idle);
	assign end_cnt_bit = !idle && (cnt_bit == cnt_bit_t'(i2c_pkg::scl_max - 1));
	assign end_cnt_num = end_cnt_bit && ({1'b0, cnt_num} == num - 4'd1);
	assign stop_req = |(cmd_r & i2c_pkg::cmd_stop);

	assign go_start = idle && cmd_vld && |(cmd & i2c_pkg::cmd_start);
	assign go_wr = idle && cmd_vld && |(cmd & i2c_pkg::cmd_write);
	assign go_rd = idle && cmd_vld && |(cmd & i2c_pkg::cmd_read);
	assign start_end = (state == i2c_pkg::bus_start) && end_cnt_num;
	assign wr_end = (state == i2c_pkg::bus_wr_data) && end_cnt_num;
	assign rd_end = (state == i2c_pkg::bus_rd_data) && end_cnt_num;
	assign ack_end = (state == i2c_pkg::bus_r_ack || state == i2c_pkg::bus_t_ack) && end_cnt_num;
	assign r_ack_stop = (state == i2c_pkg::bus_r_ack) && end_cnt_num && stop_req;
	assign stop_end = (state == i2c_pkg::bus_stop) && end_cnt_num;

	assign done = (ack_end && !stop_req) || stop_end;
	assign rd_data_vld = (state == i2c_pkg::bus_t_ack) && end_cnt_num;
	assign sda = oe ? sda_out : 1'bz;  // released for the slave, pulled up outside

	always_ff @(posedge sys_clk) begin
		if (cmd_vld)
			wr_data_r <= wr_data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= i2c_pkg::bus_idle;
			cmd_r <= '0;
			cnt_bit <= '0;
			cnt_num <= '0;
		end else begin
			state <= next_state;
			if (cmd_vld)
				cmd_r <= cmd;
			if (!idle)
				cnt_bit <= end_cnt_bit ? '0 : cnt_bit + 1'b1;
			if (end_cnt_bit)
				cnt_num <= end_cnt_num ? '0 : cnt_num + 1'b1;
		end
	end

	always_comb begin
		case (state)
			i2c_pkg::bus_wr_data, i2c_pkg::bus_rd_data: num = 4'd8;
			default: num = 4'd1;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			i2c_pkg::bus_idle: begin
				if (go_start)
					next_state = i2c_pkg::bus_start;
				else if (go_wr)
					next_state = i2c_pkg::bus_wr_data;
				else if (go_rd)
					next_state = i2c_pkg::bus_rd_data;
			end
			i2c_pkg::bus_start: if (end_cnt_num) next_state = i2c_pkg::bus_wr_data;
			i2c_pkg::bus_wr_data: if (end_cnt_num) next_state = i2c_pkg::bus_r_ack;
			i2c_pkg::bus_rd_data: if (end_cnt_num) next_state = i2c_pkg::bus_t_ack;
			i2c_pkg::bus_r_ack, i2c_pkg::bus_t_ack: begin
				if (end_cnt_num)
					next_state = stop_req ? i2c_pkg::bus_stop : i2c_pkg::bus_idle;
			end
			i2c_pkg::bus_stop: if (end_cnt_num) next_state = i2c_pkg::bus_idle;
			default: next_state = i2c_pkg::bus_idle;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			scl <= 1'b1;
		else if (cnt_bit == cnt_bit_t'((i2c_pkg::scl_max - 1) / 2) || stop_end)
			scl <= 1'b1;  // rises at mid-bit
		else if (end_cnt_bit)
			scl <= 1'b0;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			oe <= 1'b0;
		else if (go_start || go_wr || start_end || r_ack_stop || rd_end)
			oe <= 1'b1;
		else if (go_rd || wr_end || stop_end)
			oe <= 1'b0;  // slave owns sda for read bits and its ack
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sda_out <= 1'b1;
		end else begin
			case (state)
				i2c_pkg::bus_start, i2c_pkg::bus_stop: begin
					if (cnt_bit == cnt_bit_t'(i2c_pkg::scl_low_half))
						sda_out <= (state == i2c_pkg::bus_start);
					else if (cnt_bit == cnt_bit_t'(i2c_pkg::scl_high_half))
						sda_out <= (state == i2c_pkg::bus_stop);  // edge while scl is high
				end
				i2c_pkg::bus_wr_data: begin
					if (cnt_bit == cnt_bit_t'(i2c_pkg::scl_low_half))
						sda_out <= wr_data_r[3'd7 - cnt_num];  // msb first
				end
				i2c_pkg::bus_t_ack: begin
					if (cnt_bit == cnt_bit_t'(i2c_pkg::scl_low_half))
						sda_out <= |(cmd_r & i2c_pkg::cmd_nack);
				end
				default: sda_out <= 1'b1;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == i2c_pkg::bus_rd_data && cnt_bit == cnt_bit_t'(i2c_pkg::scl_high_half))
			rd_data[3'd7 - cnt_num] <= sda;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rev_ack <= 1'b0;
		else if (state == i2c_pkg::bus_r_ack && cnt_bit == cnt_bit_t'(i2c_pkg::scl_high_half))
			rev_ack <= sda;  // low means the slave acknowledged
	end

endmodule

`default_nettype wire

// File: i2c_eeprom_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c eeprom master top level
// sequencer, command buffer and byte engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module i2c_eeprom_top (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        req,
	input  wire        req_write,
	input  wire  [7:0] mem_addr,
	input  wire  [7:0] wr_data,
	output logic       busy,
	output logic       xfer_done,
	output logic       ack_err,
	output logic [7:0] rd_data,
	output logic       rd_data_vld,
	output logic       scl,
	inout  wire        sda
);

	logic push;
	logic [i2c_pkg::cmd_w-1:0] cmd_in;
	logic [7:0] data_in;
	logic cmd_vld;
	logic [i2c_pkg::cmd_w-1:0] cmd;
	logic [7:0] byte_data;  // write byte from the buffer to the engine
	logic idle;
	logic done;
	logic rev_ack;

	eeprom_access_ctrl u_ctrl (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .req(req), .req_write(req_write),
		.mem_addr(mem_addr), .wr_data(wr_data), .done(done), .rev_ack(rev_ack),
		.push(push), .cmd_in(cmd_in), .data_in(data_in), .busy(busy),
		.xfer_done(xfer_done), .ack_err(ack_err)
	);

	i2c_cmd_fifo u_fifo (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .push(push), .cmd_in(cmd_in),
		.data_in(data_in), .idle(idle), .cmd_vld(cmd_vld), .cmd(cmd), .wr_data(byte_data)
	);

	i2c_byte_master u_master (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .cmd_vld(cmd_vld), .cmd(cmd),
		.wr_data(byte_data), .idle(idle), .done(done), .rev_ack(rev_ack),
		.rd_data(rd_data), .rd_data_vld(rd_data_vld), .scl(scl), .sda(sda)
	);

endmodule

`default_nettype wire

// File: eeprom_slave_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral i2c eeprom, 256 bytes
// open-drain sda, upper addresses write protected
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module eeprom_slave_model #(
	parameter logic [7:0] protect_base = 8'hF0
) (
	input  wire scl,
	inout  wire sda
);

	logic [7:0] mem [256];
	logic [7:0] shift = 8'h00;
	logic [7:0] ptr = 8'h00;        // address pointer, kept across a repeated start
	logic sda_low = 1'b0;           // the model only ever pulls sda low
	logic reading = 1'b0;
	logic master_nack = 1'b0;
	int bit_cnt = 9;                // -1 in the start bit, 8 in the ack bit, 9 when not addressed
	int byte_idx = 0;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'hFF;
	end

	// called on the falling scl edge that ends the eighth bit of a received byte
	task automatic take_byte();
		if (byte_idx == 0) begin
			if (shift[7:1] == i2c_pkg::dev_addr) begin
				reading = shift[0];
				sda_low = 1'b1;
			end else begin
				bit_cnt = 9;  // another device is addressed
			end
		end else if (byte_idx == 1) begin
			ptr = shift;
			sda_low = 1'b1;
		end else if (ptr < protect_base) begin
			mem[ptr] = shift;
			ptr = ptr + 8'd1;
			sda_low = 1'b1;
		end
		byte_idx = byte_idx + 1;
	endtask

	always @(negedge sda) begin
		if (scl === 1'b1) begin  // start or repeated start
			bit_cnt = -1;
			byte_idx = 0;
			reading = 1'b0;
			master_nack = 1'b0;
			sda_low = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin  // stop
			bit_cnt = 9;
			sda_low = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (bit_cnt >= 0 && bit_cnt < 8 && !reading)
			shift = {shift[6:0], sda};
		else if (bit_cnt == 8 && reading)
			master_nack = sda;  // ack from the master after a read byte
	end

	always @(negedge scl) begin
		if (bit_cnt == 8) begin
			bit_cnt = 0;  // end of the ack bit
			sda_low = 1'b0;
			if (reading && !master_nack)
				sda_low = !mem[ptr][7];
		end else if (bit_cnt < 8) begin
			bit_cnt = bit_cnt + 1;
			if (reading) begin
				if (bit_cnt < 8) begin
					sda_low = !mem[ptr][7 - bit_cnt];
				end else begin
					sda_low = 1'b0;  // let the master answer
					ptr = ptr + 8'd1;
				end
			end else if (bit_cnt == 8) begin
				take_byte();
			end
		end
	end

endmodule

`default_nettype wire

// File: i2c_eeprom_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and strobe checks on the eeprom master
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module i2c_eeprom_asserts (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire req,
	input wire req_write,
	input wire busy,
	input wire xfer_done,
	input wire rd_data_vld,
	input wire scl,
	input wire sda
);

	logic read_xfer;  // the accepted request is a read

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			read_xfer <= 1'b0;
		else if (req && !busy)
			read_xfer <= !req_write;
	end

	bus_released: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!busy |-> scl && sda)
		else $error("scl or sda is low while the master is idle");

	done_in_xfer: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		xfer_done |-> busy)
		else $error("xfer_done pulsed with no transfer running");

	vld_in_read: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rd_data_vld |-> busy && read_xfer)
		else $error("rd_data_vld pulsed outside a read transfer");

endmodule

`default_nettype wire

// File: tb_i2c_eeprom.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the i2c eeprom master
// directed and random transfers checked against a shadow memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module tb_i2c_eeprom;

	localparam int seed = 34104;
	localparam int n_random = 20;
	localparam int n_trans = n_random + 7;  // random ones plus the directed ones
	localparam logic [7:0] protect_base = 8'hF0;
	localparam longint watchdog_ns = longint'(n_trans) * 40 * i2c_pkg::scl_max * 40 + 100_000;

	logic sys_clk;
	logic sys_rst_n;
	logic req;
	logic req_write;
	logic [7:0] mem_addr;
	logic [7:0] wr_data;
	wire busy;
	wire xfer_done;
	wire ack_err;
	wire [7:0] rd_data;
	wire rd_data_vld;
	wire scl;
	wire sda;

	logic [7:0] shadow [256];
	logic [7:0] exp_rd;
	logic exp_ack;
	int check_errors = 0;
	int timeout_errors = 0;
	int issued = 0;
	int reads_issued = 0;
	int done_seen = 0;
	int vld_seen = 0;

	pullup (sda);

	i2c_eeprom_top DUT (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .req(req), .req_write(req_write),
		.mem_addr(mem_addr), .wr_data(wr_data), .busy(busy), .xfer_done(xfer_done),
		.ack_err(ack_err), .rd_data(rd_data), .rd_data_vld(rd_data_vld), .scl(scl), .sda(sda)
	);

	eeprom_slave_model #(.protect_base(protect_base)) u_eeprom (.scl(scl), .sda(sda));

	bind i2c_eeprom_top i2c_eeprom_asserts u_asserts (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .req(req), .req_write(req_write),
		.busy(busy), .xfer_done(xfer_done), .rd_data_vld(rd_data_vld), .scl(scl), .sda(sda)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// applies one transfer to the shadow memory, returns the expected ack_err
	function automatic logic predict_transfer(input logic is_write, input logic [7:0] addr,
			input logic [7:0] data, output logic [7:0] rd_value);
		rd_value = shadow[addr];
		if (!is_write)
			return 1'b0;
		if (addr >= protect_base)
			return 1'b1;  // data byte is not acknowledged
		shadow[addr] = data;
		return 1'b0;
	endfunction

	task automatic report_mismatch(input string what);
		check_errors++;
		$display("CHECK FAILED at %0t ns: %s", $time, what);
	endtask

	task automatic start_transfer(input logic is_write, input logic [7:0] addr,
			input logic [7:0] data);
		logic [7:0] rd_value;
		logic ack_value;
		ack_value = predict_transfer(is_write, addr, data, rd_value);
		exp_rd = rd_value;
		exp_ack = ack_value;
		issued++;
		if (!is_write)
			reads_issued++;
		@(posedge sys_clk);
		req <= 1'b1;
		req_write <= is_write;
		mem_addr <= addr;
		wr_data <= data;
		@(posedge sys_clk);
		req <= 1'b0;
	endtask

	task automatic wait_transfer();
		@(negedge sys_clk);
		while (!xfer_done)
			@(negedge sys_clk);
		@(posedge sys_clk);  // the checker has seen this xfer_done by now
	endtask

	task automatic run_transfer(input logic is_write, input logic [7:0] addr,
			input logic [7:0] data);
		start_transfer(is_write, addr, data);
		wait_transfer();
	endtask

	// the second write lands while busy is high and must leave no trace
	task automatic request_while_busy(input logic [7:0] addr, input logic [7:0] data,
			input logic [7:0] ignored_addr);
		start_transfer(1'b1, addr, data);
		repeat (4) @(negedge sys_clk);
		assert (busy) else report_mismatch("busy is low during a write transfer");
		@(posedge sys_clk);
		req <= 1'b1;
		req_write <= 1'b1;
		mem_addr <= ignored_addr;
		wr_data <= ~data;
		@(posedge sys_clk);
		req <= 1'b0;
		wait_transfer();
	endtask

	always @(negedge sys_clk) begin
		if (sys_rst_n && rd_data_vld) begin
			vld_seen++;
			assert (rd_data == exp_rd)
				else report_mismatch($sformatf("rd_data %h, expected %h", rd_data, exp_rd));
		end
		if (sys_rst_n && xfer_done) begin
			done_seen++;
			assert (ack_err == exp_ack)
				else report_mismatch($sformatf("ack_err %b, expected %b", ack_err, exp_ack));
		end
	end

	initial begin
		#(watchdog_ns);
		timeout_errors++;
		$display("watchdog expired after %0d ns with transfers still outstanding", watchdog_ns);
		$display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		logic rnd_write;
		logic [7:0] rnd_addr;
		logic [7:0] rnd_data;
		void'($urandom(seed));
		sys_rst_n = 1'b0;
		req = 1'b0;
		req_write = 1'b0;
		mem_addr = 8'h00;
		wr_data = 8'h00;
		for (int i = 0; i < 256; i++)
			shadow[i] = 8'hFF;
		repeat (10) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		assert (scl && sda && !busy && !xfer_done && !rd_data_vld)
			else report_mismatch("bus or strobes not idle after reset");

		run_transfer(1'b1, 8'h3C, 8'hA5);
		run_transfer(1'b0, 8'h3C, 8'h00);

		for (int i = 0; i < n_random; i++) begin
			rnd_write = 1'($urandom % 2);
			if ($urandom % 4 == 0)
				rnd_addr = protect_base + 8'($urandom % 16);  // protected range
			else
				rnd_addr = 8'h20 + 8'($urandom % 8);
			rnd_data = 8'($urandom);
			run_transfer(rnd_write, rnd_addr, rnd_data);
		end

		run_transfer(1'b1, 8'hF4, 8'h12);
		run_transfer(1'b0, 8'hF4, 8'h00);

		request_while_busy(8'h51, 8'h66, 8'h52);
		run_transfer(1'b0, 8'h52, 8'h00);
		run_transfer(1'b0, 8'h51, 8'h00);

		repeat (5) @(negedge sys_clk);
		assert (done_seen == issued)
			else report_mismatch($sformatf("%0d xfer_done for %0d requests", done_seen, issued));
		assert (vld_seen == reads_issued)
			else report_mismatch($sformatf("%0d rd_data_vld for %0d reads", vld_seen, reads_issued));

		$display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
i2c_pkg.sv
i2c_cmd_fifo.sv
eeprom_access_ctrl.sv
i2c_byte_master.sv
i2c_eeprom_top.sv
eeprom_slave_model.sv
i2c_eeprom_asserts.sv
tb_i2c_eeprom.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_i2c_eeprom \
	-f verilog.f -o tb_i2c_eeprom > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_i2c_eeprom > sim.log 2>&1 || echo "simulator exited with an error status"
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
